//--- logic/mips_isa_pkg.sv
`default_nettype none

package mips_isa_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0] reg_addr_t;

    localparam reg_addr_t REG_V0 = 5'd2;  // return value, visible as register_v0
    localparam reg_addr_t REG_RA = 5'd31; // link register for JAL

    typedef enum logic [5:0] {
        OP_SPECIAL = 6'b000000, // R-type, operation in funct
        OP_J       = 6'b000010,
        OP_JAL     = 6'b000011,
        OP_BEQ     = 6'b000100,
        OP_BNE     = 6'b000101,
        OP_ADDIU   = 6'b001001,
        OP_SLTI    = 6'b001010,
        OP_SLTIU   = 6'b001011,
        OP_ANDI    = 6'b001100,
        OP_ORI     = 6'b001101,
        OP_XORI    = 6'b001110,
        OP_LUI     = 6'b001111,
        OP_LB      = 6'b100000,
        OP_LW      = 6'b100011,
        OP_LBU     = 6'b100100,
        OP_SB      = 6'b101000,
        OP_SW      = 6'b101011
    } opcode_t;

    typedef enum logic [5:0] {
        FN_SLL  = 6'b000000,
        FN_SRL  = 6'b000010,
        FN_SRA  = 6'b000011,
        FN_JR   = 6'b001000,
        FN_JALR = 6'b001001,
        FN_ADDU = 6'b100001,
        FN_SUBU = 6'b100011,
        FN_AND  = 6'b100100,
        FN_OR   = 6'b100101,
        FN_XOR  = 6'b100110,
        FN_SLT  = 6'b101010,
        FN_SLTU = 6'b101011
    } funct_t;

    typedef struct packed {
        opcode_t   opcode;
        reg_addr_t rs;
        reg_addr_t rt;
        reg_addr_t rd;
        logic [4:0] shamt;
        funct_t    funct;
    } r_format_t;

    typedef struct packed {
        opcode_t    opcode;
        reg_addr_t  rs;
        reg_addr_t  rt;
        logic [15:0] imm;
    } i_format_t;

    typedef struct packed {
        opcode_t     opcode;
        logic [25:0] index;
    } j_format_t;

    // the three formats share the opcode bits, so one word can be viewed any way
    typedef union packed {
        r_format_t r;
        i_format_t i;
        j_format_t j;
    } instr_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLTU,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_LUI
    } alu_op_t;

endpackage

`default_nettype wire

//--- logic/mips_bus_pkg.sv
`default_nettype none

package mips_bus_pkg;

    typedef struct packed {
        mips_isa_pkg::word_t address;
        logic                read;
        logic                write;
        mips_isa_pkg::word_t writedata;
        logic [3:0]          byteenable;
    } bus_req_t;

    localparam logic [3:0] BE_WORD = 4'b1111;
    localparam logic [3:0] BE_NONE = 4'b0000;

    localparam mips_isa_pkg::word_t RESET_VECTOR    = 32'hBFC0_0000;
    localparam mips_isa_pkg::word_t HALT_ADDRESS    = 32'h0000_0000; // fetching here stops the core
    localparam mips_isa_pkg::word_t WORD_ALIGN_MASK = 32'hFFFF_FFFC;

endpackage

`default_nettype wire

//--- logic/register_file.sv
`default_nettype none

module register_file (
    input  logic                    clk,
    input  logic                    reset,
    input  mips_isa_pkg::reg_addr_t rs_addr,
    input  mips_isa_pkg::reg_addr_t rt_addr,
    input  mips_isa_pkg::reg_addr_t waddr,
    input  logic                    we,
    input  mips_isa_pkg::word_t     wdata,
    output mips_isa_pkg::word_t     rs_value,
    output mips_isa_pkg::word_t     rt_value,
    output mips_isa_pkg::word_t     v0_value
);

    mips_isa_pkg::word_t regs [32];

    assign rs_value = regs[rs_addr];
    assign rt_value = regs[rt_addr];
    assign v0_value = regs[mips_isa_pkg::REG_V0];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && waddr != 5'd0) begin // $zero is never written
            regs[waddr] <= wdata;
        end
    end

    zero_reg_zero: assert property (@(posedge clk) disable iff (reset)
        regs[0] == '0);

endmodule

`default_nettype wire

//--- logic/alu.sv
`default_nettype none

module alu (
    input  mips_isa_pkg::alu_op_t op,
    input  mips_isa_pkg::word_t   a,
    input  mips_isa_pkg::word_t   b,
    input  logic [4:0]            shamt,
    output mips_isa_pkg::word_t   result
);

    // a is always rs, b is rt or the extended immediate
    always_comb begin
        case (op)
            mips_isa_pkg::ALU_ADD:  result = a + b;
            mips_isa_pkg::ALU_SUB:  result = a - b;
            mips_isa_pkg::ALU_AND:  result = a & b;
            mips_isa_pkg::ALU_OR:   result = a | b;
            mips_isa_pkg::ALU_XOR:  result = a ^ b;
            mips_isa_pkg::ALU_SLT:  result = {31'b0, $signed(a) < $signed(b)};
            mips_isa_pkg::ALU_SLTU: result = {31'b0, a < b};
            mips_isa_pkg::ALU_SLL:  result = b << shamt; // shifts act on rt
            mips_isa_pkg::ALU_SRL:  result = b >> shamt;
            mips_isa_pkg::ALU_SRA:  result = $signed(b) >>> shamt;
            mips_isa_pkg::ALU_LUI:  result = {b[15:0], 16'h0000};
            default:                result = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- logic/load_store_unit.sv
`default_nettype none

module load_store_unit (
    input  mips_isa_pkg::instr_t    instr,
    input  mips_isa_pkg::word_t     rs_value,
    input  mips_isa_pkg::word_t     rt_value,
    input  mips_isa_pkg::word_t     readdata,
    output mips_bus_pkg::bus_req_t  data_req,
    output mips_isa_pkg::word_t     load_value
);

    mips_isa_pkg::word_t eff_addr;
    mips_isa_pkg::word_t lane_data;
    logic [1:0]          lane;
    logic [3:0]          lane_be;

    assign eff_addr  = rs_value + {{16{instr.i.imm[15]}}, instr.i.imm};
    assign lane      = eff_addr[1:0];
    assign lane_be   = 4'b0001 << lane;            // one-hot enable of the addressed byte
    assign lane_data = readdata >> {lane, 3'b000}; // addressed byte moved down to bits 7:0

    always_comb begin
        data_req.address    = eff_addr & mips_bus_pkg::WORD_ALIGN_MASK;
        data_req.read       = 1'b0;
        data_req.write      = 1'b0;
        data_req.writedata  = rt_value;
        data_req.byteenable = mips_bus_pkg::BE_NONE;
        load_value          = readdata;
        case (instr.i.opcode)
            mips_isa_pkg::OP_LW: begin
                data_req.read       = 1'b1;
                data_req.byteenable = mips_bus_pkg::BE_WORD;
            end
            mips_isa_pkg::OP_LB: begin
                data_req.read       = 1'b1;
                data_req.byteenable = lane_be;
                load_value          = {{24{lane_data[7]}}, lane_data[7:0]};
            end
            mips_isa_pkg::OP_LBU: begin
                data_req.read       = 1'b1;
                data_req.byteenable = lane_be;
                load_value          = {24'h000000, lane_data[7:0]};
            end
            mips_isa_pkg::OP_SW: begin
                data_req.write      = 1'b1;
                data_req.byteenable = mips_bus_pkg::BE_WORD;
            end
            mips_isa_pkg::OP_SB: begin
                data_req.write      = 1'b1;
                data_req.byteenable = lane_be;
                data_req.writedata  = {4{rt_value[7:0]}}; // byte copied to every lane
            end
            default: data_req.byteenable = mips_bus_pkg::BE_NONE;
        endcase
    end

endmodule

`default_nettype wire

//--- logic/pc_unit.sv
`default_nettype none

module pc_unit (
    input  logic                 clk,
    input  logic                 reset,
    input  mips_isa_pkg::instr_t instr,
    input  mips_isa_pkg::word_t  rs_value,
    input  mips_isa_pkg::word_t  rt_value,
    input  logic                 step,
    output mips_isa_pkg::word_t  pc,
    output mips_isa_pkg::word_t  link_value
);

    mips_isa_pkg::word_t pc_plus4, branch_target, jump_target, next_target, target;
    logic                delay, is_transfer, taken;

    assign pc_plus4      = pc + 32'd4;
    assign link_value    = pc + 32'd8; // skips the delay slot
    assign branch_target = pc_plus4 + {{14{instr.i.imm[15]}}, instr.i.imm, 2'b00};
    assign jump_target   = {pc_plus4[31:28], instr.j.index, 2'b00};

    always_comb begin
        is_transfer = 1'b1;
        taken       = 1'b0;
        next_target = jump_target;
        case (instr.r.opcode)
            mips_isa_pkg::OP_BEQ: begin
                taken       = (rs_value == rt_value);
                next_target = branch_target;
            end
            mips_isa_pkg::OP_BNE: begin
                taken       = (rs_value != rt_value);
                next_target = branch_target;
            end
            mips_isa_pkg::OP_J, mips_isa_pkg::OP_JAL: taken = 1'b1;
            mips_isa_pkg::OP_SPECIAL: begin
                is_transfer = (instr.r.funct == mips_isa_pkg::FN_JR)
                           || (instr.r.funct == mips_isa_pkg::FN_JALR);
                taken       = is_transfer;
                next_target = rs_value;
            end
            default: is_transfer = 1'b0;
        endcase
    end

    // the delay-slot instruction steps to the latched target, a taken transfer arms it
    always_ff @(posedge clk) begin
        if (reset) begin
            pc    <= mips_bus_pkg::RESET_VECTOR;
            delay <= 1'b0;
        end else if (step) begin
            pc    <= delay ? target : pc_plus4;
            delay <= taken;
        end
    end

    always_ff @(posedge clk) begin
        if (step && taken) begin
            target <= next_target;
        end
    end

    no_transfer_in_slot: assert property (@(posedge clk) disable iff (reset)
        step && is_transfer |-> !delay);

endmodule

`default_nettype wire

//--- logic/cpu_sequencer.sv
`default_nettype none

module cpu_sequencer (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    waitrequest,
    input  mips_isa_pkg::word_t     readdata,
    input  mips_isa_pkg::word_t     pc,
    input  mips_bus_pkg::bus_req_t  data_req,
    input  mips_isa_pkg::word_t     alu_result,
    input  mips_isa_pkg::word_t     load_value,
    input  mips_isa_pkg::word_t     link_value,
    input  mips_isa_pkg::word_t     rt_value,
    output mips_bus_pkg::bus_req_t  bus_req,
    output mips_isa_pkg::instr_t    instr,
    output mips_isa_pkg::alu_op_t   alu_op,
    output mips_isa_pkg::word_t     alu_b,
    output logic                    pc_step,
    output logic                    reg_we,
    output mips_isa_pkg::reg_addr_t reg_waddr,
    output mips_isa_pkg::word_t     reg_wdata,
    output logic                    active
);

    typedef enum logic [2:0] {
        ST_FETCH  = 3'b000,
        ST_EXEC   = 3'b001,
        ST_MEM    = 3'b010,
        ST_HALTED = 3'b111
    } state_t;

    typedef enum logic [1:0] {WB_NONE, WB_ALU, WB_LOAD, WB_LINK} wb_sel_t;

    state_t               state;
    wb_sel_t              wb_sel;
    mips_isa_pkg::instr_t ir;
    mips_isa_pkg::word_t  imm_sext, imm_zext;
    logic                 stall, mem_op, done;

    // fetched word arrives in the first execute cycle, after that it lives in ir
    assign instr    = (state == ST_EXEC && !stall) ? mips_isa_pkg::instr_t'(readdata) : ir;
    assign imm_sext = {{16{instr.i.imm[15]}}, instr.i.imm};
    assign imm_zext = {16'h0000, instr.i.imm};
    assign mem_op   = data_req.read | data_req.write;
    assign done     = !(mem_op && waitrequest); // non-memory instructions never wait
    assign pc_step  = (state == ST_EXEC) && done;

    always_comb begin
        alu_op    = mips_isa_pkg::ALU_ADD;
        wb_sel    = WB_ALU;
        reg_waddr = instr.i.rt;
        alu_b     = imm_sext;
        case (instr.r.opcode)
            mips_isa_pkg::OP_SPECIAL: begin
                reg_waddr = instr.r.rd;
                alu_b     = rt_value;
                case (instr.r.funct)
                    mips_isa_pkg::FN_ADDU: alu_op = mips_isa_pkg::ALU_ADD;
                    mips_isa_pkg::FN_SUBU: alu_op = mips_isa_pkg::ALU_SUB;
                    mips_isa_pkg::FN_AND:  alu_op = mips_isa_pkg::ALU_AND;
                    mips_isa_pkg::FN_OR:   alu_op = mips_isa_pkg::ALU_OR;
                    mips_isa_pkg::FN_XOR:  alu_op = mips_isa_pkg::ALU_XOR;
                    mips_isa_pkg::FN_SLT:  alu_op = mips_isa_pkg::ALU_SLT;
                    mips_isa_pkg::FN_SLTU: alu_op = mips_isa_pkg::ALU_SLTU;
                    mips_isa_pkg::FN_SLL:  alu_op = mips_isa_pkg::ALU_SLL;
                    mips_isa_pkg::FN_SRL:  alu_op = mips_isa_pkg::ALU_SRL;
                    mips_isa_pkg::FN_SRA:  alu_op = mips_isa_pkg::ALU_SRA;
                    mips_isa_pkg::FN_JALR: wb_sel = WB_LINK; // return address goes to rd
                    default:               wb_sel = WB_NONE;
                endcase
            end
            mips_isa_pkg::OP_ADDIU: alu_op = mips_isa_pkg::ALU_ADD;
            mips_isa_pkg::OP_SLTI:  alu_op = mips_isa_pkg::ALU_SLT;
            mips_isa_pkg::OP_SLTIU: alu_op = mips_isa_pkg::ALU_SLTU;
            mips_isa_pkg::OP_LUI:   alu_op = mips_isa_pkg::ALU_LUI;
            mips_isa_pkg::OP_ANDI: begin
                alu_op = mips_isa_pkg::ALU_AND;
                alu_b  = imm_zext; // logical immediates are zero extended
            end
            mips_isa_pkg::OP_ORI: begin
                alu_op = mips_isa_pkg::ALU_OR;
                alu_b  = imm_zext;
            end
            mips_isa_pkg::OP_XORI: begin
                alu_op = mips_isa_pkg::ALU_XOR;
                alu_b  = imm_zext;
            end
            mips_isa_pkg::OP_LB, mips_isa_pkg::OP_LBU, mips_isa_pkg::OP_LW: wb_sel = WB_LOAD;
            mips_isa_pkg::OP_JAL: begin
                wb_sel    = WB_LINK;
                reg_waddr = mips_isa_pkg::REG_RA;
            end
            default: wb_sel = WB_NONE; // stores, BEQ, BNE and J write nothing
        endcase
    end

    // loads write rt in the memory-access cycle, everything else on a completed execute
    assign reg_we = (state == ST_EXEC && done && (wb_sel == WB_ALU || wb_sel == WB_LINK))
                 || (state == ST_MEM && wb_sel == WB_LOAD);

    always_comb begin
        case (wb_sel)
            WB_LOAD: reg_wdata = load_value;
            WB_LINK: reg_wdata = link_value;
            default: reg_wdata = alu_result;
        endcase
    end

    always_comb begin
        bus_req.address    = '0;
        bus_req.read       = 1'b0;
        bus_req.write      = 1'b0;
        bus_req.writedata  = '0;
        bus_req.byteenable = mips_bus_pkg::BE_NONE;
        case (state)
            ST_FETCH: begin
                bus_req.address    = pc;
                bus_req.read       = 1'b1;
                bus_req.byteenable = mips_bus_pkg::BE_WORD;
            end
            ST_EXEC: bus_req = data_req; // idle unless the instruction is a load or store
            default: bus_req.read = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state  <= ST_FETCH;
            active <= 1'b1;
            stall  <= 1'b0;
        end else begin
            case (state)
                ST_FETCH: begin
                    if (pc == mips_bus_pkg::HALT_ADDRESS) begin
                        state  <= ST_HALTED;
                        active <= 1'b0;
                    end else if (!waitrequest) begin
                        state <= ST_EXEC;
                    end
                end
                ST_EXEC: begin
                    stall <= !done;
                    if (done) begin
                        state <= (wb_sel == WB_LOAD) ? ST_MEM : ST_FETCH;
                    end
                end
                ST_MEM:  state <= ST_FETCH;
                default: state <= ST_HALTED;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == ST_EXEC) begin
            ir <= instr;
        end
    end

    state_legal: assert property (@(posedge clk) disable iff (reset)
        state inside {ST_FETCH, ST_EXEC, ST_MEM, ST_HALTED});

endmodule

`default_nettype wire

//--- logic/mips_cpu_bus.sv
`default_nettype none

module mips_cpu_bus (
    input  logic                clk,
    input  logic                reset,
    output logic                active,
    output mips_isa_pkg::word_t register_v0,
    output mips_isa_pkg::word_t address,
    output logic                write,
    output logic                read,
    input  logic                waitrequest,
    output mips_isa_pkg::word_t writedata,
    output logic [3:0]          byteenable,
    input  mips_isa_pkg::word_t readdata
);

    mips_bus_pkg::bus_req_t bus_req;
    mips_bus_pkg::bus_req_t data_req;
    mips_isa_pkg::instr_t   instr;
    mips_isa_pkg::alu_op_t  alu_op;
    mips_isa_pkg::reg_addr_t reg_waddr;
    mips_isa_pkg::word_t    pc, link_value, reg_wdata;
    mips_isa_pkg::word_t    rs_value, rt_value, alu_b, alu_result, load_value;
    logic                   pc_step, reg_we;

    assign address    = bus_req.address;
    assign read       = bus_req.read;
    assign write      = bus_req.write;
    assign writedata  = bus_req.writedata;
    assign byteenable = bus_req.byteenable;

    cpu_sequencer sequencer_i (
        .clk         (clk),
        .reset       (reset),
        .waitrequest (waitrequest),
        .readdata    (readdata),
        .pc          (pc),
        .data_req    (data_req),
        .alu_result  (alu_result),
        .load_value  (load_value),
        .link_value  (link_value),
        .rt_value    (rt_value),
        .bus_req     (bus_req),
        .instr       (instr),
        .alu_op      (alu_op),
        .alu_b       (alu_b),
        .pc_step     (pc_step),
        .reg_we      (reg_we),
        .reg_waddr   (reg_waddr),
        .reg_wdata   (reg_wdata),
        .active      (active)
    );

    register_file register_file_i (
        .clk      (clk),
        .reset    (reset),
        .rs_addr  (instr.r.rs),
        .rt_addr  (instr.r.rt),
        .waddr    (reg_waddr),
        .we       (reg_we),
        .wdata    (reg_wdata),
        .rs_value (rs_value),
        .rt_value (rt_value),
        .v0_value (register_v0)
    );

    alu alu_i (
        .op     (alu_op),
        .a      (rs_value),
        .b      (alu_b),
        .shamt  (instr.r.shamt),
        .result (alu_result)
    );

    load_store_unit load_store_unit_i (
        .instr      (instr),
        .rs_value   (rs_value),
        .rt_value   (rt_value),
        .readdata   (readdata),
        .data_req   (data_req),
        .load_value (load_value)
    );

    pc_unit pc_unit_i (
        .clk        (clk),
        .reset      (reset),
        .instr      (instr),
        .rs_value   (rs_value),
        .rt_value   (rt_value),
        .step       (pc_step),
        .pc         (pc),
        .link_value (link_value)
    );

endmodule

`default_nettype wire

//--- test/clock_gen.sv
`default_nettype none

module clock_gen (
    output logic clk,
    output logic reset
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int RESET_CYCLES = 10;

    initial begin
        clk   = 1'b0;
        reset = 1'b1;
        forever #20 clk = ~clk; // 40 ns period
    end

    // reset moves on the falling edge like every other DUT input
    task automatic hold_reset();
        @(negedge clk);
        reset = 1'b1;
        repeat (RESET_CYCLES) @(negedge clk);
        reset = 1'b0;
    endtask

endmodule

`default_nettype wire

//--- test/avalon_memory.sv
`default_nettype none

module avalon_memory (
    input  logic                clk,
    input  logic                reset,
    input  logic                stretch,
    input  mips_isa_pkg::word_t address,
    input  logic                read,
    input  logic                write,
    input  mips_isa_pkg::word_t writedata,
    input  logic [3:0]          byteenable,
    output logic                waitrequest,
    output mips_isa_pkg::word_t readdata,
    output logic [3:0]          last_byteenable
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int DEPTH = 1024; // program at the reset vector and data at 0x100 land apart

    mips_isa_pkg::word_t words [DEPTH];

    assign waitrequest = stretch; // random wait bit comes in on the falling edge

    initial begin
        readdata        = '0;
        last_byteenable = '0;
    end

    function automatic int unsigned slot(input mips_isa_pkg::word_t addr);
        return int'(addr[11:2]);
    endfunction

    function automatic mips_isa_pkg::word_t merge_bytes(input mips_isa_pkg::word_t old_word,
                                                        input mips_isa_pkg::word_t new_word,
                                                        input logic [3:0] lanes);
        mips_isa_pkg::word_t merged;
        merged = old_word;
        for (int b = 0; b < 4; b++) begin
            if (lanes[b]) begin
                merged[8*b +: 8] = new_word[8*b +: 8];
            end
        end
        return merged;
    endfunction

    task automatic clear_words();
        for (int i = 0; i < DEPTH; i++) begin
            words[i] = '0;
        end
    endtask

    task automatic preload(input mips_isa_pkg::word_t addr, input mips_isa_pkg::word_t data);
        words[slot(addr)] = data;
    endtask

    function automatic mips_isa_pkg::word_t peek(input mips_isa_pkg::word_t addr);
        return words[slot(addr)];
    endfunction

    // a request completes on the rising edge with waitrequest low, read data follows it
    always @(posedge clk) begin
        if (reset) begin
            last_byteenable <= '0;
        end else if (!waitrequest) begin
            if (read) begin
                readdata <= words[slot(address)];
            end
            if (write) begin
                words[slot(address)] <= merge_bytes(words[slot(address)], writedata, byteenable);
                last_byteenable      <= byteenable;
            end
        end
    end

endmodule

`default_nettype wire

//--- test/mips_cpu_bus_tb.sv
`default_nettype none

module mips_cpu_bus_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int PROG_LEN    = 12;
    localparam int BASE_ROWS   = 6;
    localparam int NUM_ROWS    = 2 * BASE_ROWS; // each program runs again with random waits
    localparam int CYCLE_LIMIT = NUM_ROWS * 400;
    localparam logic [31:0] SEED = 32'h2d2b_d149;
    localparam mips_isa_pkg::word_t DATA_ADDRESS = 32'h0000_0100;
    localparam logic [4:0] ZERO = 5'd0;
    localparam logic [4:0] T0   = 5'd8;
    localparam logic [4:0] T1   = 5'd9;
    localparam logic [4:0] T2   = 5'd10;
    localparam logic [4:0] T3   = 5'd11;
    localparam logic [4:0] T4   = 5'd12;
    localparam logic [4:0] T5   = 5'd13;
    localparam logic [4:0] V0   = mips_isa_pkg::REG_V0;
    localparam logic [4:0] RA   = mips_isa_pkg::REG_RA;

    typedef struct packed {
        logic [0:PROG_LEN-1][31:0] code;
        logic                      random_wait;
        mips_isa_pkg::word_t       v0;
        mips_isa_pkg::word_t       data;
        logic [3:0]                byteenable;
    } test_row_t;

    test_row_t           rows [NUM_ROWS];
    mips_isa_pkg::word_t program_q [$];
    int                  row_count   = 0;
    int unsigned         cycle_count = 0;
    logic                clk, reset, active, read, write, waitrequest;
    logic                stretch     = 1'b0;
    logic                random_wait = 1'b0;
    logic [3:0]          byteenable, last_be;
    mips_isa_pkg::word_t register_v0, address, writedata, readdata;

    clock_gen clock_i (.clk(clk), .reset(reset));

    mips_cpu_bus dut_i (
        .clk         (clk),
        .reset       (reset),
        .active      (active),
        .register_v0 (register_v0),
        .address     (address),
        .write       (write),
        .read        (read),
        .waitrequest (waitrequest),
        .writedata   (writedata),
        .byteenable  (byteenable),
        .readdata    (readdata)
    );

    avalon_memory memory_i (
        .clk             (clk),
        .reset           (reset),
        .stretch         (stretch),
        .address         (address),
        .read            (read),
        .write           (write),
        .writedata       (writedata),
        .byteenable      (byteenable),
        .waitrequest     (waitrequest),
        .readdata        (readdata),
        .last_byteenable (last_be)
    );

    function automatic mips_isa_pkg::word_t r_instr(input mips_isa_pkg::funct_t funct,
                                                    input logic [4:0] rd, rs, rt, shamt);
        return {mips_isa_pkg::OP_SPECIAL, rs, rt, rd, shamt, funct};
    endfunction

    function automatic mips_isa_pkg::word_t i_instr(input mips_isa_pkg::opcode_t op,
                                                    input logic [4:0] rt, rs,
                                                    input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic mips_isa_pkg::word_t j_instr(input mips_isa_pkg::opcode_t op,
                                                    input mips_isa_pkg::word_t target);
        return {op, target[27:2]};
    endfunction

    task automatic check_value(input string what, input mips_isa_pkg::word_t actual,
                               input mips_isa_pkg::word_t expected);
        if (actual !== expected) begin
            $display("FAIL at %0t: %s is %h, expected %h", $time, what, actual, expected);
            $display("Test failed");
            $fatal(1, "value mismatch");
        end
    endtask

    // closes the program with jr $zero and its slot, then stores both wait versions
    task automatic add_row(input mips_isa_pkg::word_t v0, input mips_isa_pkg::word_t data,
                           input logic [3:0] be);
        test_row_t row;
        program_q.push_back(r_instr(mips_isa_pkg::FN_JR, ZERO, ZERO, ZERO, 5'd0));
        program_q.push_back(32'h0000_0000);
        row = '0;
        for (int i = 0; i < program_q.size(); i++) begin
            row.code[i] = program_q[i];
        end
        row.v0         = v0;
        row.data       = data;
        row.byteenable = be;
        rows[row_count] = row;
        row.random_wait = 1'b1;
        rows[row_count + BASE_ROWS] = row;
        row_count++;
        program_q.delete();
    endtask

    task automatic build_rows();
        // 0x1233d688 ^ 0x12345678
        program_q.push_back(i_instr(mips_isa_pkg::OP_ADDIU, T0, ZERO, 16'h7ff0));
        program_q.push_back(i_instr(mips_isa_pkg::OP_LUI, T1, ZERO, 16'h1234));
        program_q.push_back(i_instr(mips_isa_pkg::OP_ORI, T1, T1, 16'h5678));
        program_q.push_back(r_instr(mips_isa_pkg::FN_SUBU, T2, T1, T0, 5'd0));
        program_q.push_back(r_instr(mips_isa_pkg::FN_XOR, V0, T2, T1, 5'd0));
        add_row(32'h0007_80f0, 32'h0, mips_bus_pkg::BE_NONE);
        // 0xf + 0x10 - 3 + 1 from -5 put through compares and shifts
        program_q.push_back(i_instr(mips_isa_pkg::OP_ADDIU, T0, ZERO, 16'hfffb));
        program_q.push_back(r_instr(mips_isa_pkg::FN_SLT, T1, T0, ZERO, 5'd0));
        program_q.push_back(i_instr(mips_isa_pkg::OP_SLTIU, T2, T0, 16'hffff));
        program_q.push_back(r_instr(mips_isa_pkg::FN_SRA, T3, ZERO, T0, 5'd1));
        program_q.push_back(r_instr(mips_isa_pkg::FN_SRL, T4, ZERO, T0, 5'd28));
        program_q.push_back(r_instr(mips_isa_pkg::FN_SLL, T5, ZERO, T1, 5'd4));
        program_q.push_back(r_instr(mips_isa_pkg::FN_ADDU, V0, T4, T5, 5'd0));
        program_q.push_back(r_instr(mips_isa_pkg::FN_ADDU, V0, V0, T3, 5'd0));
        program_q.push_back(r_instr(mips_isa_pkg::FN_ADDU, V0, V0, T2, 5'd0));
        add_row(32'h0000_001d, 32'h0, mips_bus_pkg::BE_NONE);
        program_q.push_back(i_instr(mips_isa_pkg::OP_LUI, T0, ZERO, 16'hcafe));
        program_q.push_back(i_instr(mips_isa_pkg::OP_ORI, T0, T0, 16'hbabe));
        program_q.push_back(i_instr(mips_isa_pkg::OP_SW, T0, ZERO, 16'h0100));
        program_q.push_back(i_instr(mips_isa_pkg::OP_LW, V0, ZERO, 16'h0100));
        add_row(32'hcafe_babe, 32'hcafe_babe, mips_bus_pkg::BE_WORD);
        // lane 1 gets 0xa5, then lbu minus lb gives 0xa5 - 0xffffffa5
        program_q.push_back(i_instr(mips_isa_pkg::OP_LUI, T0, ZERO, 16'h1122));
        program_q.push_back(i_instr(mips_isa_pkg::OP_ORI, T0, T0, 16'h3344));
        program_q.push_back(i_instr(mips_isa_pkg::OP_SW, T0, ZERO, 16'h0100));
        program_q.push_back(i_instr(mips_isa_pkg::OP_ADDIU, T1, ZERO, 16'h00a5));
        program_q.push_back(i_instr(mips_isa_pkg::OP_SB, T1, ZERO, 16'h0101));
        program_q.push_back(i_instr(mips_isa_pkg::OP_LB, T2, ZERO, 16'h0101));
        program_q.push_back(i_instr(mips_isa_pkg::OP_LBU, T3, ZERO, 16'h0101));
        program_q.push_back(r_instr(mips_isa_pkg::FN_SUBU, V0, T3, T2, 5'd0));
        add_row(32'h0000_0100, 32'h1122_a544, 4'b0010);
        // taken beq skips 0x10, its slot adds 1, bne falls through
        program_q.push_back(i_instr(mips_isa_pkg::OP_ADDIU, T0, ZERO, 16'd3));
        program_q.push_back(i_instr(mips_isa_pkg::OP_ADDIU, T1, ZERO, 16'd3));
        program_q.push_back(i_instr(mips_isa_pkg::OP_BEQ, T1, T0, 16'd2));
        program_q.push_back(i_instr(mips_isa_pkg::OP_ADDIU, V0, V0, 16'h0001));
        program_q.push_back(i_instr(mips_isa_pkg::OP_ADDIU, V0, V0, 16'h0010));
        program_q.push_back(i_instr(mips_isa_pkg::OP_BNE, T1, T0, 16'd2));
        program_q.push_back(i_instr(mips_isa_pkg::OP_ADDIU, V0, V0, 16'h0100));
        program_q.push_back(i_instr(mips_isa_pkg::OP_ADDIU, V0, V0, 16'h1000));
        add_row(32'h0000_1101, 32'h0, mips_bus_pkg::BE_NONE);
        // jal to word 4 links reset vector + 8, slot sets t0 to 7
        program_q.push_back(j_instr(mips_isa_pkg::OP_JAL, mips_bus_pkg::RESET_VECTOR + 32'd16));
        program_q.push_back(i_instr(mips_isa_pkg::OP_ADDIU, T0, ZERO, 16'd7));
        program_q.push_back(i_instr(mips_isa_pkg::OP_ADDIU, V0, ZERO, 16'h0055));
        program_q.push_back(32'h0000_0000);
        program_q.push_back(r_instr(mips_isa_pkg::FN_ADDU, V0, RA, T0, 5'd0));
        add_row(32'hbfc0_000f, 32'h0, mips_bus_pkg::BE_NONE);
    endtask

    task automatic run_row(input int n);
        test_row_t           row;
        mips_isa_pkg::word_t held_v0;
        row = rows[n];
        memory_i.clear_words();
        for (int i = 0; i < PROG_LEN; i++) begin
            memory_i.preload(mips_bus_pkg::RESET_VECTOR + 32'(4 * i), row.code[i]);
        end
        random_wait = row.random_wait;
        clock_i.hold_reset();
        check_value($sformatf("row %0d active after reset", n), active, 1'b1);
        check_value($sformatf("row %0d read after reset", n), read, 1'b1);
        check_value($sformatf("row %0d write after reset", n), write, 1'b0);
        check_value($sformatf("row %0d first address", n), address, mips_bus_pkg::RESET_VECTOR);
        check_value($sformatf("row %0d first byteenable", n), byteenable, mips_bus_pkg::BE_WORD);
        while (active) begin
            @(negedge clk);
        end
        held_v0 = register_v0;
        repeat (4) begin
            @(negedge clk);
            check_value($sformatf("row %0d read while halted", n), read, 1'b0);
            check_value($sformatf("row %0d write while halted", n), write, 1'b0);
            check_value($sformatf("row %0d active while halted", n), active, 1'b0);
            check_value($sformatf("row %0d held register_v0", n), register_v0, held_v0);
        end
        check_value($sformatf("row %0d register_v0", n), register_v0, row.v0);
        check_value($sformatf("row %0d data word", n), memory_i.peek(DATA_ADDRESS), row.data);
        check_value($sformatf("row %0d last byteenable", n), last_be, row.byteenable);
    endtask

    // wait states are drawn here so that the seed and the draws share one process
    initial begin
        void'($urandom(SEED));
        forever begin
            @(negedge clk);
            stretch = random_wait && ($urandom_range(1, 0) == 1);
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count > CYCLE_LIMIT) begin
            $display("Timeout after %0d cycles, the core never halted", cycle_count);
            $display("Test failed");
            $fatal(1, "simulation stopped by timeout");
        end
    end

    initial begin
        build_rows();
        for (int n = 0; n < NUM_ROWS; n++) begin
            run_row(n);
        end
        $display("Test completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

//--- mips_cpu_bus.f
logic/mips_isa_pkg.sv
logic/mips_bus_pkg.sv
logic/register_file.sv
logic/alu.sv
logic/load_store_unit.sv
logic/pc_unit.sv
logic/cpu_sequencer.sv
logic/mips_cpu_bus.sv
test/clock_gen.sv
test/avalon_memory.sv
test/mips_cpu_bus_tb.sv
